/* Makefile */
VERILATOR = verilator
TOP       = tb_apb_soc_ctrl
RTL_TOP   = apb_soc_ctrl
FILELIST  = vlog.f
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* apb_ctrl_fsm.sv */
// APB transfer controller
`include "soc_ctrl_macros.svh"

module apb_ctrl_fsm (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic [`SOC_CTRL_ADDR_W-1:0] paddr_i,
  input  logic [`SOC_CTRL_DATA_W-1:0] pwdata_i,
  input  logic                        pwrite_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  output logic [`SOC_CTRL_DATA_W-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  soc_reg_if.initiator                regs_bus,
  soc_reg_if.initiator                pad_bus
);
  import soc_ctrl_pkg::*;

  apb_state_e                  state;
  logic                        any_hit;
  logic [`SOC_CTRL_DATA_W-1:0] rsp_data;

  // both blocks see the same access, each decides on its own
  assign regs_bus.strobe = (state == ACCESS);
  assign regs_bus.write  = pwrite_i;
  assign regs_bus.addr   = paddr_i;
  assign regs_bus.wdata  = pwdata_i;

  assign pad_bus.strobe  = (state == ACCESS);
  assign pad_bus.write   = pwrite_i;
  assign pad_bus.addr    = paddr_i;
  assign pad_bus.wdata   = pwdata_i;

  assign any_hit = regs_bus.hit | pad_bus.hit;

  always_comb begin
    if (pwrite_i) begin
      rsp_data = '0;  // writes return nothing
    end else if (regs_bus.hit) begin
      rsp_data = regs_bus.rdata;
    end else if (pad_bus.hit) begin
      rsp_data = pad_bus.rdata;
    end else begin
      rsp_data = `SOC_CTRL_ERR_DATA;
    end
  end

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= IDLE;
      prdata_o  <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (psel_i && penable_i)
            state <= ACCESS;
        end
        ACCESS: begin
          // blocks act on this edge, response is captured alongside
          prdata_o  <= rsp_data;
          pslverr_o <= ~any_hit;
          pready_o  <= 1'b1;
          state     <= RESPOND;
        end
        RESPOND: begin
          pready_o  <= 1'b0;
          pslverr_o <= 1'b0;
          state     <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* apb_soc_ctrl.sv */
// SoC control block top level
`include "soc_ctrl_macros.svh"

module apb_soc_ctrl #(
  parameter int unsigned NB_CORES    = 8,
  parameter int unsigned NB_CLUSTERS = 1
) (
  input  logic                                                 HCLK,
  input  logic                                                 HRESETn,
  input  logic [`SOC_CTRL_ADDR_W-1:0]                          paddr_i,
  input  logic [`SOC_CTRL_DATA_W-1:0]                          pwdata_i,
  input  logic                                                 pwrite_i,
  input  logic                                                 psel_i,
  input  logic                                                 penable_i,
  output logic [`SOC_CTRL_DATA_W-1:0]                          prdata_o,
  output logic                                                 pready_o,
  output logic                                                 pslverr_o,
  input  logic                                                 sel_fll_clk_i,
  input  logic                                                 bootsel_i,
  input  logic                                                 fc_fetch_en_valid_i,
  input  logic                                                 fc_fetch_en_i,
  input  logic [`SOC_CTRL_JTAG_W-1:0]                          soc_jtag_reg_i,
  output logic [`SOC_CTRL_JTAG_W-1:0]                          soc_jtag_reg_o,
  output logic [31:0]                                          fc_bootaddr_o,
  output logic                                                 fc_fetchen_o,
  output logic                                                 cluster_pow_o,
  output logic                                                 cluster_byp_o,
  output logic                                                 cluster_rstn_o,
  output logic                                                 cluster_fetch_enable_o,
  output logic                                                 cluster_irq_o,
  output logic [63:0]                                          cluster_boot_addr_o,
  output logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADMUX-1:0] pad_mux_o
);

  soc_reg_if regs_bus ();
  soc_reg_if pad_bus ();

  apb_ctrl_fsm u_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pwrite_i  (pwrite_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .regs_bus  (regs_bus.initiator),
    .pad_bus   (pad_bus.initiator)
  );

  soc_ctrl_regs #(
    .NB_CORES    (NB_CORES),
    .NB_CLUSTERS (NB_CLUSTERS)
  ) u_regs (
    .HCLK                   (HCLK),
    .HRESETn                (HRESETn),
    .bus                    (regs_bus.target),
    .sel_fll_clk_i          (sel_fll_clk_i),
    .bootsel_i              (bootsel_i),
    .fc_fetch_en_valid_i    (fc_fetch_en_valid_i),
    .fc_fetch_en_i          (fc_fetch_en_i),
    .soc_jtag_reg_i         (soc_jtag_reg_i),
    .soc_jtag_reg_o         (soc_jtag_reg_o),
    .fc_bootaddr_o          (fc_bootaddr_o),
    .fc_fetchen_o           (fc_fetchen_o),
    .cluster_pow_o          (cluster_pow_o),
    .cluster_byp_o          (cluster_byp_o),
    .cluster_rstn_o         (cluster_rstn_o),
    .cluster_fetch_enable_o (cluster_fetch_enable_o),
    .cluster_irq_o          (cluster_irq_o),
    .cluster_boot_addr_o    (cluster_boot_addr_o)
  );

  pad_cfg_regs u_pads (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .bus       (pad_bus.target),
    .pad_cfg_o (pad_cfg_o),
    .pad_mux_o (pad_mux_o)
  );

endmodule

/* pad_cfg_regs.sv */
// Pad mux and configuration table
`include "soc_ctrl_macros.svh"

module pad_cfg_regs (
  input  logic                                                 HCLK,
  input  logic                                                 HRESETn,
  soc_reg_if.target                                            bus,
  output logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADMUX-1:0] pad_mux_o
);
  import soc_ctrl_pkg::*;

  logic [`SOC_CTRL_IO_IDX_W-1:0] r_io_pad;  // current index
  logic                          win;
  logic [7:0]                    win_idx;
  logic                          win_ok;
  logic [`SOC_CTRL_IO_IDX_W-1:0] wr_idx;

  assign win     = (bus.addr[11:10] == `SOC_CTRL_PAD_WIN);
  assign win_idx = bus.addr[9:2];
  assign win_ok  = (win_idx < `SOC_CTRL_N_IO);
  assign wr_idx  = bus.wdata[`SOC_CTRL_IO_IDX_W-1:0];

  assign bus.hit = win || (bus.addr == WCFGFUN) || (bus.addr == RCFGFUN);

  always_comb begin
    bus.rdata = '0;
    if (win) begin
      if (win_ok) begin
        bus.rdata[8 +: `SOC_CTRL_NBIT_PADCFG] = pad_cfg_o[win_idx[`SOC_CTRL_IO_IDX_W-1:0]];
        bus.rdata[0 +: `SOC_CTRL_NBIT_PADMUX] = pad_mux_o[win_idx[`SOC_CTRL_IO_IDX_W-1:0]];
      end else begin
        bus.rdata = `SOC_CTRL_PAD_OOR_DATA;
      end
    end else begin
      // indirect view of the current index
      bus.rdata[0 +: `SOC_CTRL_IO_IDX_W]     = r_io_pad;
      bus.rdata[16 +: `SOC_CTRL_NBIT_PADMUX] = pad_mux_o[r_io_pad];
      bus.rdata[24 +: `SOC_CTRL_NBIT_PADCFG] = pad_cfg_o[r_io_pad];
    end
  end

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      r_io_pad  <= '0;
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (bus.strobe) begin
      if (win) begin
        if (!bus.write) begin
          r_io_pad <= win_idx[`SOC_CTRL_IO_IDX_W-1:0];  // reads move the index too
        end else if (win_ok) begin
          r_io_pad <= win_idx[`SOC_CTRL_IO_IDX_W-1:0];
          pad_mux_o[win_idx[`SOC_CTRL_IO_IDX_W-1:0]] <= bus.wdata[0 +: `SOC_CTRL_NBIT_PADMUX];
          pad_cfg_o[win_idx[`SOC_CTRL_IO_IDX_W-1:0]] <= bus.wdata[8 +: `SOC_CTRL_NBIT_PADCFG];
        end
      end else if (bus.write && ((bus.addr == WCFGFUN) || (bus.addr == RCFGFUN))) begin
        r_io_pad <= wr_idx;  // both indirect offsets set the index
        if (bus.addr == WCFGFUN) begin
          pad_mux_o[wr_idx] <= bus.wdata[16 +: `SOC_CTRL_NBIT_PADMUX];
          pad_cfg_o[wr_idx] <= bus.wdata[24 +: `SOC_CTRL_NBIT_PADCFG];
        end
      end
    end
  end

endmodule

/* soc_ctrl_macros.svh */
// SoC control block parameters
`ifndef SOC_CTRL_MACROS_SVH
`define SOC_CTRL_MACROS_SVH

// pad table geometry
`define SOC_CTRL_N_IO         32
`define SOC_CTRL_NBIT_PADCFG  6
`define SOC_CTRL_NBIT_PADMUX  2
`define SOC_CTRL_IO_IDX_W     5

// bus geometry
`define SOC_CTRL_ADDR_W       12
`define SOC_CTRL_DATA_W       32

// pad window sits at 0x400..0x7FC, picked out by addr[11:10]
`define SOC_CTRL_PAD_WIN      2'b01

`define SOC_CTRL_JTAG_W       8

// reset values
`define SOC_CTRL_BOOTADDR_RST 32'h1A00_0080
`define SOC_CTRL_CLUCTRL_RST  4'b1001  // rstn high, bypass high

// read data for accesses that find nothing
`define SOC_CTRL_ERR_DATA     32'hDEAD_BEEF
`define SOC_CTRL_PAD_OOR_DATA 32'h0095_BEEF

`endif

/* soc_ctrl_pkg.sv */
// SoC control types
package soc_ctrl_pkg;

  // transfer sequencing of the APB controller
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ACCESS  = 2'd1,
    RESPOND = 2'd2
  } apb_state_e;

  // register offsets, the pad window is decoded separately
  typedef enum logic [11:0] {
    INFO               = 12'h000,
    FCBOOT             = 12'h004,
    FCFETCH            = 12'h008,
    WCFGFUN            = 12'h060,
    RCFGFUN            = 12'h064,
    CLUSTER_CTRL       = 12'h070,
    JTAGREG            = 12'h074,
    CLUSTER_IRQ        = 12'h07C,
    CLUSTER_BOOT_ADDR0 = 12'h080,
    CLUSTER_BOOT_ADDR1 = 12'h084,
    CORESTATUS         = 12'h0A0,
    CS_RO              = 12'h0C0,
    BOOTSEL            = 12'h0C4,
    CLKSEL             = 12'h0C8
  } soc_reg_e;

endpackage

/* soc_ctrl_regs.sv */
// Boot and cluster control registers
`include "soc_ctrl_macros.svh"

module soc_ctrl_regs #(
  parameter int unsigned NB_CORES    = 8,
  parameter int unsigned NB_CLUSTERS = 1
) (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  soc_reg_if.target                   bus,
  input  logic                        sel_fll_clk_i,
  input  logic                        bootsel_i,
  input  logic                        fc_fetch_en_valid_i,
  input  logic                        fc_fetch_en_i,
  input  logic [`SOC_CTRL_JTAG_W-1:0] soc_jtag_reg_i,
  output logic [`SOC_CTRL_JTAG_W-1:0] soc_jtag_reg_o,
  output logic [31:0]                 fc_bootaddr_o,
  output logic                        fc_fetchen_o,
  output logic                        cluster_pow_o,
  output logic                        cluster_byp_o,
  output logic                        cluster_rstn_o,
  output logic                        cluster_fetch_enable_o,
  output logic                        cluster_irq_o,
  output logic [63:0]                 cluster_boot_addr_o
);
  import soc_ctrl_pkg::*;

  localparam logic [15:0] N_CORES    = 16'(NB_CORES);
  localparam logic [15:0] N_CLUSTERS = 16'(NB_CLUSTERS);

  logic [31:0]                 r_bootaddr;
  logic                        r_fetchen;
  logic [3:0]                  r_cluster_ctrl;  // {rstn, fetch_en, pow, byp}
  logic                        r_cluster_irq;
  logic [63:0]                 r_cluster_boot;
  logic [31:0]                 r_corestatus;
  logic [`SOC_CTRL_JTAG_W-1:0] r_jtag_rego;
  logic [`SOC_CTRL_JTAG_W-1:0] r_jtag_sync0;
  logic [`SOC_CTRL_JTAG_W-1:0] r_jtag_sync1;
  logic                        r_bootsel;
  logic                        rd_hit;
  logic                        wr_hit;
  logic                        wr_en;

  // read view
  always_comb begin
    rd_hit    = 1'b1;
    bus.rdata = '0;
    case (bus.addr)
      INFO:               bus.rdata = {N_CORES, N_CLUSTERS};
      FCBOOT:             bus.rdata = r_bootaddr;
      FCFETCH:            bus.rdata[0] = r_fetchen;
      CLUSTER_CTRL:       bus.rdata[3:0] = r_cluster_ctrl;
      JTAGREG:            bus.rdata[15:0] = {r_jtag_sync1, r_jtag_rego};
      CLUSTER_IRQ:        bus.rdata[0] = r_cluster_irq;
      CLUSTER_BOOT_ADDR0: bus.rdata = r_cluster_boot[31:0];
      CLUSTER_BOOT_ADDR1: bus.rdata = r_cluster_boot[63:32];
      CORESTATUS:         bus.rdata = r_corestatus;
      CS_RO:              bus.rdata = r_corestatus;
      BOOTSEL:            bus.rdata[0] = r_bootsel;
      CLKSEL:             bus.rdata[0] = sel_fll_clk_i;  // live, not registered
      default:            rd_hit = 1'b0;
    endcase
  end

  // writable subset only, read-only offsets fall through to an error
  always_comb begin
    case (bus.addr)
      FCBOOT, FCFETCH, CLUSTER_CTRL, JTAGREG, CLUSTER_IRQ,
      CLUSTER_BOOT_ADDR0, CLUSTER_BOOT_ADDR1, CORESTATUS: wr_hit = 1'b1;
      default:                                            wr_hit = 1'b0;
    endcase
  end

  assign bus.hit = bus.write ? wr_hit : rd_hit;
  assign wr_en   = bus.strobe & bus.write;

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      r_bootaddr     <= `SOC_CTRL_BOOTADDR_RST;
      r_fetchen      <= 1'b0;
      r_cluster_ctrl <= `SOC_CTRL_CLUCTRL_RST;
      r_cluster_irq  <= 1'b0;
      r_cluster_boot <= '0;
      r_corestatus   <= '0;
      r_jtag_rego    <= '0;
      r_jtag_sync0   <= '0;
      r_jtag_sync1   <= '0;
    end else begin
      r_jtag_sync0 <= soc_jtag_reg_i;
      r_jtag_sync1 <= r_jtag_sync0;
      if (fc_fetch_en_valid_i)
        r_fetchen <= fc_fetch_en_i;
      if (wr_en) begin
        case (bus.addr)
          FCBOOT:             r_bootaddr <= bus.wdata;
          FCFETCH:            r_fetchen <= bus.wdata[0];  // bus wins over side-band
          CLUSTER_CTRL:       r_cluster_ctrl <= bus.wdata[3:0];
          JTAGREG:            r_jtag_rego <= bus.wdata[`SOC_CTRL_JTAG_W-1:0];
          CLUSTER_IRQ:        r_cluster_irq <= bus.wdata[0];
          CLUSTER_BOOT_ADDR0: r_cluster_boot[31:0] <= bus.wdata;
          CLUSTER_BOOT_ADDR1: r_cluster_boot[63:32] <= bus.wdata;
          CORESTATUS:         r_corestatus <= bus.wdata;
          default:            ;
        endcase
      end
    end
  end

  // strap is captured while reset is held and then frozen
  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn)
      r_bootsel <= bootsel_i;
  end

  assign fc_bootaddr_o          = r_bootaddr;
  assign fc_fetchen_o           = r_fetchen;
  assign cluster_byp_o          = r_cluster_ctrl[0];
  assign cluster_pow_o          = r_cluster_ctrl[1];
  assign cluster_fetch_enable_o = r_cluster_ctrl[2];
  assign cluster_rstn_o         = r_cluster_ctrl[3];
  assign cluster_irq_o          = r_cluster_irq;
  assign cluster_boot_addr_o    = r_cluster_boot;
  assign soc_jtag_reg_o         = r_jtag_rego;

endmodule

/* soc_reg_if.sv */
// Register block access port
`include "soc_ctrl_macros.svh"

interface soc_reg_if;

  logic                          strobe;  // one cycle per access
  logic                          write;
  logic [`SOC_CTRL_ADDR_W-1:0]   addr;
  logic [`SOC_CTRL_DATA_W-1:0]   wdata;
  logic                          hit;     // block claims addr for this direction
  logic [`SOC_CTRL_DATA_W-1:0]   rdata;

  modport initiator (
    output strobe, write, addr, wdata,
    input  hit, rdata
  );

  modport target (
    input  strobe, write, addr, wdata,
    output hit, rdata
  );

endinterface

/* tb_apb_soc_ctrl.sv */
// SoC control block testbench
`include "soc_ctrl_macros.svh"

module tb_apb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int NB_CORES    = 12;
  localparam int NB_CLUSTERS = 2;
  localparam logic [11:0] WR_REGS [8] = '{FCBOOT, FCFETCH, CLUSTER_CTRL, JTAGREG, CLUSTER_IRQ,
                                          CLUSTER_BOOT_ADDR0, CLUSTER_BOOT_ADDR1, CORESTATUS};

  logic                                                 HCLK;
  logic                                                 HRESETn;
  logic [11:0]                                          paddr_i;
  logic [31:0]                                          pwdata_i;
  logic                                                 pwrite_i;
  logic                                                 psel_i;
  logic                                                 penable_i;
  logic [31:0]                                          prdata_o;
  logic                                                 pready_o;
  logic                                                 pslverr_o;
  logic                                                 sel_fll_clk_i;
  logic                                                 bootsel_i;
  logic                                                 fc_fetch_en_valid_i;
  logic                                                 fc_fetch_en_i;
  logic [7:0]                                           soc_jtag_reg_i;
  logic [7:0]                                           soc_jtag_reg_o;
  logic [31:0]                                          fc_bootaddr_o;
  logic                                                 fc_fetchen_o;
  logic                                                 cluster_pow_o;
  logic                                                 cluster_byp_o;
  logic                                                 cluster_rstn_o;
  logic                                                 cluster_fetch_enable_o;
  logic                                                 cluster_irq_o;
  logic [63:0]                                          cluster_boot_addr_o;
  logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADCFG-1:0] pad_cfg_o;
  logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADMUX-1:0] pad_mux_o;

  // reference model state
  logic [31:0]                                          m_bootaddr;
  logic                                                 m_fetchen;
  logic [3:0]                                           m_clu_ctrl;  // {rstn, fetch, pow, byp}
  logic                                                 m_clu_irq;
  logic [63:0]                                          m_clu_boot;
  logic [31:0]                                          m_corestatus;
  logic [7:0]                                           m_jtag_o;
  logic [7:0]                                           m_jtag_in;
  logic                                                 m_bootsel;
  logic                                                 m_clksel;
  logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADCFG-1:0] m_pad_cfg;
  logic [`SOC_CTRL_N_IO-1:0][`SOC_CTRL_NBIT_PADMUX-1:0] m_pad_mux;
  logic [4:0]                                           m_pad_idx;
  logic [31:0]                                          exp_rdata;
  logic                                                 exp_err;
  logic [31:0]                                          rng_state;
  apb_state_e                                           fsm_state;  // for debug prints
  int err_cnt = 0;
  int test_err_base = 0;
  int xfer_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  apb_soc_ctrl #(.NB_CORES(NB_CORES), .NB_CLUSTERS(NB_CLUSTERS)) UUT (.*);

  assign fsm_state = UUT.u_fsm.state;

  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  function automatic void report_mismatch(input string sig, input logic [191:0] exp_v,
                                          input logic [191:0] got_v);
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
    err_cnt++;
  endfunction

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [11:0] pad_addr(input int n);
    return 12'h400 + 12'(n * 4);
  endfunction

  // response checks, one cycle of PREADY per transfer
  a_prdata: assert property (@(posedge HCLK) disable iff (!HRESETn) pready_o |-> prdata_o == exp_rdata)
    else report_mismatch("prdata_o", $sampled(exp_rdata), $sampled(prdata_o));
  a_pslverr: assert property (@(posedge HCLK) disable iff (!HRESETn) pready_o |-> pslverr_o == exp_err)
    else report_mismatch("pslverr_o", $sampled(exp_err), $sampled(pslverr_o));
  a_bootaddr: assert property (@(posedge HCLK) pready_o |-> fc_bootaddr_o == m_bootaddr)
    else report_mismatch("fc_bootaddr_o", $sampled(m_bootaddr), $sampled(fc_bootaddr_o));
  a_fetchen: assert property (@(posedge HCLK) pready_o |-> fc_fetchen_o == m_fetchen)
    else report_mismatch("fc_fetchen_o", $sampled(m_fetchen), $sampled(fc_fetchen_o));
  a_cluster: assert property (@(posedge HCLK) pready_o |-> {cluster_rstn_o, cluster_fetch_enable_o,
      cluster_pow_o, cluster_byp_o, cluster_irq_o} == {m_clu_ctrl, m_clu_irq})
    else report_mismatch("cluster control outputs", $sampled({m_clu_ctrl, m_clu_irq}),
      $sampled({cluster_rstn_o, cluster_fetch_enable_o, cluster_pow_o, cluster_byp_o,
      cluster_irq_o}));
  a_clu_boot: assert property (@(posedge HCLK) pready_o |-> cluster_boot_addr_o == m_clu_boot)
    else report_mismatch("cluster_boot_addr_o", $sampled(m_clu_boot),
      $sampled(cluster_boot_addr_o));
  a_jtag: assert property (@(posedge HCLK) pready_o |-> soc_jtag_reg_o == m_jtag_o)
    else report_mismatch("soc_jtag_reg_o", $sampled(m_jtag_o), $sampled(soc_jtag_reg_o));
  a_pad_cfg: assert property (@(posedge HCLK) pready_o |-> pad_cfg_o == m_pad_cfg)
    else report_mismatch("pad_cfg_o", $sampled(m_pad_cfg), $sampled(pad_cfg_o));
  a_pad_mux: assert property (@(posedge HCLK) pready_o |-> pad_mux_o == m_pad_mux)
    else report_mismatch("pad_mux_o", $sampled(m_pad_mux), $sampled(pad_mux_o));

  // expected response of one access, model updated as the DUT should be
  task automatic model_access(input logic wr, input logic [11:0] a, input logic [31:0] d);
    logic        hit;
    logic [31:0] rd;
    hit = 1'b1;
    rd  = '0;
    if (a[11:10] == 2'b01) begin
      if (a[9:2] < `SOC_CTRL_N_IO) begin
        rd = {18'd0, m_pad_cfg[a[6:2]], 6'd0, m_pad_mux[a[6:2]]};
        if (wr) begin
          m_pad_mux[a[6:2]] = d[1:0];
          m_pad_cfg[a[6:2]] = d[13:8];
        end
        m_pad_idx = a[6:2];
      end else begin
        rd = `SOC_CTRL_PAD_OOR_DATA;
        if (!wr)
          m_pad_idx = a[6:2];  // out of range reads still move the index
      end
    end else if (!wr) begin
      case (a)
        INFO:               rd = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        FCBOOT:             rd = m_bootaddr;
        FCFETCH:            rd = {31'd0, m_fetchen};
        CLUSTER_CTRL:       rd = {28'd0, m_clu_ctrl};
        JTAGREG:            rd = {16'd0, m_jtag_in, m_jtag_o};
        CLUSTER_IRQ:        rd = {31'd0, m_clu_irq};
        CLUSTER_BOOT_ADDR0: rd = m_clu_boot[31:0];
        CLUSTER_BOOT_ADDR1: rd = m_clu_boot[63:32];
        CORESTATUS, CS_RO:  rd = m_corestatus;
        BOOTSEL:            rd = {31'd0, m_bootsel};
        CLKSEL:             rd = {31'd0, m_clksel};
        WCFGFUN, RCFGFUN:   rd = {2'd0, m_pad_cfg[m_pad_idx], 6'd0, m_pad_mux[m_pad_idx],
                                  11'd0, m_pad_idx};
        default:            hit = 1'b0;
      endcase
    end else begin
      case (a)
        FCBOOT:             m_bootaddr = d;
        FCFETCH:            m_fetchen = d[0];
        CLUSTER_CTRL:       m_clu_ctrl = d[3:0];
        JTAGREG:            m_jtag_o = d[7:0];
        CLUSTER_IRQ:        m_clu_irq = d[0];
        CLUSTER_BOOT_ADDR0: m_clu_boot[31:0] = d;
        CLUSTER_BOOT_ADDR1: m_clu_boot[63:32] = d;
        CORESTATUS:         m_corestatus = d;
        WCFGFUN: begin
          m_pad_idx            = d[4:0];
          m_pad_mux[d[4:0]]    = d[17:16];
          m_pad_cfg[d[4:0]]    = d[29:24];
        end
        RCFGFUN:            m_pad_idx = d[4:0];
        default:            hit = 1'b0;
      endcase
    end
    exp_err   = !hit;
    exp_rdata = wr ? 32'd0 : (hit ? rd : `SOC_CTRL_ERR_DATA);
  endtask

  task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] d);
    int n;
    @(posedge HCLK);
    model_access(wr, a, d);
    paddr_i   <= a;
    pwdata_i  <= d;
    pwrite_i  <= wr;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge HCLK);
    penable_i <= 1'b1;
    n = 0;
    @(negedge HCLK);
    while (!pready_o && n < 20) begin
      @(negedge HCLK);
      n++;
    end
    if (!pready_o) begin
      $display("timeout: no PREADY within 20 cycles, addr %h, fsm in %s", a, fsm_state.name());
      $display("CHECKS FAILED");
      $finish;
    end else begin
      @(posedge HCLK);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      xfer_cnt++;
    end
  endtask

  task automatic apb_write(input logic [11:0] a, input logic [31:0] d);
    apb_xfer(1'b1, a, d);
  endtask

  task automatic apb_read(input logic [11:0] a);
    apb_xfer(1'b0, a, 32'd0);
  endtask

  task automatic end_test(input string name);
    @(negedge HCLK);  // let the last response checks settle
    if (err_cnt == test_err_base) begin
      $display("test %s: pass", name);
      pass_cnt++;
    end else begin
      $display("test %s: FAIL with %0d errors", name, err_cnt - test_err_base);
      fail_cnt++;
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    logic [31:0] d;
    logic        v;
    int          pads[8];
    HRESETn             = 1'b0;
    paddr_i             = '0;
    pwdata_i            = '0;
    pwrite_i            = 1'b0;
    psel_i              = 1'b0;
    penable_i           = 1'b0;
    sel_fll_clk_i       = 1'b0;
    bootsel_i           = 1'b1;  // strap seen during reset
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    soc_jtag_reg_i      = '0;
    rng_state           = 32'd27114;
    m_bootaddr          = `SOC_CTRL_BOOTADDR_RST;
    m_fetchen           = 1'b0;
    m_clu_ctrl          = 4'b1001;
    m_clu_irq           = 1'b0;
    m_clu_boot          = '0;
    m_corestatus        = '0;
    m_jtag_o            = '0;
    m_jtag_in           = '0;
    m_bootsel           = 1'b1;
    m_clksel            = 1'b0;
    m_pad_cfg           = '1;
    m_pad_mux           = '0;
    m_pad_idx           = '0;
    repeat (5) @(posedge HCLK);
    HRESETn   <= 1'b1;
    bootsel_i <= 1'b0;  // strap must stay frozen
    @(negedge HCLK);
    assert ({prdata_o, pready_o, pslverr_o} == 34'd0)
      else report_mismatch("prdata_o/pready_o/pslverr_o", 0, {prdata_o, pready_o, pslverr_o});

    apb_read(FCBOOT);
    apb_read(CLUSTER_CTRL);
    apb_read(INFO);
    apb_read(BOOTSEL);
    end_test("reset_state");

    foreach (WR_REGS[i]) begin
      apb_write(WR_REGS[i], next_rand());
      apb_read(WR_REGS[i]);
    end
    apb_read(CS_RO);
    end_test("reg_write_readback");

    for (int k = 0; k < 8; k++) begin
      pads[k] = int'(next_rand() % 32);
      apb_write(pad_addr(pads[k]), next_rand());
    end
    for (int k = 0; k < 8; k++)
      apb_read(pad_addr(pads[k]));
    apb_write(WCFGFUN, next_rand());
    apb_write(RCFGFUN, next_rand() & 32'h1F);
    apb_read(RCFGFUN);
    apb_read(WCFGFUN);
    apb_read(pad_addr(40));  // beyond the pad count
    end_test("pad_table");

    apb_read(12'h0F0);
    apb_write(INFO, next_rand());
    apb_write(CLKSEL, next_rand());
    apb_read(FCBOOT);
    apb_read(RCFGFUN);  // rejected writes leave the pad index alone
    end_test("errors");

    @(posedge HCLK);
    d = next_rand();
    soc_jtag_reg_i <= d[7:0];
    m_jtag_in = d[7:0];
    repeat (3) @(posedge HCLK);  // two sync stages plus margin
    apb_read(JTAGREG);
    @(posedge HCLK);
    v = ~m_fetchen;
    fc_fetch_en_i       <= v;
    fc_fetch_en_valid_i <= 1'b1;
    m_fetchen = v;
    @(posedge HCLK);
    fc_fetch_en_valid_i <= 1'b0;
    apb_read(FCFETCH);
    for (int k = 0; k < 2; k++) begin
      @(posedge HCLK);
      sel_fll_clk_i <= ~m_clksel;
      m_clksel = ~m_clksel;
      apb_read(CLKSEL);
    end
    end_test("side_band");

    $display("tests passed %0d, failed %0d, transfers %0d, errors %0d",
             pass_cnt, fail_cnt, xfer_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
soc_ctrl_pkg.sv
soc_reg_if.sv
apb_ctrl_fsm.sv
soc_ctrl_regs.sv
pad_cfg_regs.sv
apb_soc_ctrl.sv
tb_apb_soc_ctrl.sv
